// File: frontend_top.f
design/isa_pkg.sv
design/decode_pkg.sv
design/fetch_latch.sv
design/decoder.sv
design/dispatch_stage.sv
design/frontend_top.sv
verif/frontend_checker.sv
verif/frontend_tb.sv

// File: Bender.yml
package:
  name: frontend_top

sources:
  - design/isa_pkg.sv
  - design/decode_pkg.sv
  - design/fetch_latch.sv
  - design/decoder.sv
  - design/dispatch_stage.sv
  - design/frontend_top.sv
  - target: simulation
    files:
      - verif/frontend_checker.sv
      - verif/frontend_tb.sv

// File: verif/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb import isa_pkg::*, decode_pkg::*; ();

	localparam int k_issue = 0;
	localparam int k_csr   = 1;
	localparam int k_ill   = 2;
	localparam int k_none  = 3;
	localparam int k_halt  = 4;

	logic clock = 1'b0;
	logic reset = 1'b1;
	logic flush = 1'b0;
	logic in_valid = 1'b0;
	logic [xlen-1:0] inst = '0;
	logic [xlen-1:0] in_pc = '0;

	logic issue_alu, issue_btu, issue_mult, issue_lsu;
	logic [xlen-1:0] out_pc, out_imm;
	op_func_t out_func;
	logic [reg_idx_w-1:0] out_src1, out_src2, out_dest;
	logic out_rs1_valid, out_rs2_valid, out_imm_valid, out_pc_valid;
	logic csr_op, illegal, halted;
	logic [count_w-1:0] dispatch_count;

	// stimulus table; fields are {func, src1, src2, dest, imm, rs1v, rs2v, immv, pcv}
	string        row_name[$];
	logic [31:0]  row_word[$];
	logic [31:0]  row_pc[$];
	bit           row_flush[$];
	bit           row_gap[$];
	int           row_kind[$];
	fu_t          row_fu[$];
	logic [55:0]  row_fields[$];

	bit flush_next = 0;
	bit gap_next = 0;
	bit expect_drop = 0;
	logic [31:0] next_pc = 32'h0000_1000;
	int cycles = 0;
	int limit = 0;
	bit halted_exp = 0;
	logic [15:0] count_exp = '0;

	always #10 clock = ~clock;

	frontend_top u_frontend_top (.*);

	frontend_checker u_checker (.*);

	task automatic add_row(input string name, input logic [31:0] word, input int kind,
			input fu_t fu, input logic [55:0] fields);
		row_name.push_back(name);
		row_word.push_back(word);
		row_pc.push_back(next_pc);
		row_flush.push_back(flush_next);
		row_gap.push_back(gap_next);
		row_kind.push_back(expect_drop ? k_none : kind);
		row_fu.push_back(fu);
		row_fields.push_back(fields);
		next_pc += 4;
	endtask

	task automatic add_reg(input string name, input logic [6:0] f7, input logic [2:0] f3,
			input fu_t fu, input op_func_t func);
		logic [4:0] rs1, rs2, rd;
		rs1 = 5'($urandom);
		rs2 = 5'($urandom);
		rd  = 5'($urandom);
		add_row(name, {f7, rs2, rs1, f3, rd, op_reg}, k_issue, fu,
			{func, rs1, rs2, rd, 32'h0, 4'b1100});
	endtask

	// shifts keep their upper seven immediate bits fixed
	task automatic add_imm(input string name, input logic [2:0] f3, input op_func_t func,
			input bit shift, input logic [6:0] hi7);
		logic [4:0] rs1, rd;
		logic [11:0] imm;
		rs1 = 5'($urandom);
		rd  = 5'($urandom);
		imm = shift ? {hi7, 5'($urandom)} : 12'($urandom);
		add_row(name, {imm, rs1, f3, rd, op_imm}, k_issue, fu_alu,
			{func, rs1, 5'd0, rd, {{20{imm[11]}}, imm}, 4'b1010});
	endtask

	task automatic add_upper(input string name, input logic [6:0] op);
		logic [4:0] rd;
		logic [19:0] imm;
		rd  = 5'($urandom);
		imm = 20'($urandom);
		add_row(name, {imm, rd, op}, k_issue, fu_alu,
			{alu_add, 5'd0, 5'd0, rd, imm, 12'h0, 3'b001, op == op_auipc});
	endtask

	task automatic add_branch(input string name, input logic [2:0] f3, input op_func_t func);
		logic [4:0] rs1, rs2;
		logic [12:0] b;
		rs1 = 5'($urandom);
		rs2 = 5'($urandom);
		b   = {12'($urandom), 1'b0};
		add_row(name, {b[12], b[10:5], rs2, rs1, f3, b[4:1], b[11], op_branch}, k_issue,
			fu_btu, {func, rs1, rs2, 5'd0, {{19{b[12]}}, b}, 4'b1111});
	endtask

	task automatic add_jumps();
		logic [4:0] rs1, rd;
		logic [20:0] j;
		logic [11:0] imm;
		rd = 5'($urandom);
		j  = {20'($urandom), 1'b0};
		add_row("jal", {j[20], j[10:1], j[11], j[19:12], rd, op_jal}, k_issue, fu_btu,
			{btu_jal, 5'd0, 5'd0, rd, {{11{j[20]}}, j}, 4'b0011});
		rs1 = 5'($urandom);
		rd  = 5'($urandom);
		imm = 12'($urandom);
		add_row("jalr", {imm, rs1, f3_jalr, rd, op_jalr}, k_issue, fu_btu,
			{btu_jalr, rs1, 5'd0, rd, {{20{imm[11]}}, imm}, 4'b1011});
	endtask

	task automatic build_table();
		add_reg("add", f7_base, f3_add, fu_alu, alu_add);
		add_reg("sub", f7_alt, f3_add, fu_alu, alu_sub);
		add_reg("sll", f7_base, f3_sll, fu_alu, alu_sll);
		add_reg("slt", f7_base, f3_slt, fu_alu, alu_slt);
		add_reg("sltu", f7_base, f3_sltu, fu_alu, alu_sltu);
		add_reg("xor", f7_base, f3_xor, fu_alu, alu_xor);
		add_reg("srl", f7_base, f3_sr, fu_alu, alu_srl);
		add_reg("sra", f7_alt, f3_sr, fu_alu, alu_sra);
		add_reg("or", f7_base, f3_or, fu_alu, alu_or);
		add_reg("and", f7_base, f3_and, fu_alu, alu_and);
		add_imm("addi", f3_add, alu_add, 0, '0);
		add_imm("slti", f3_slt, alu_slt, 0, '0);
		add_imm("sltiu", f3_sltu, alu_sltu, 0, '0);
		add_imm("xori", f3_xor, alu_xor, 0, '0);
		add_imm("ori", f3_or, alu_or, 0, '0);
		add_imm("andi", f3_and, alu_and, 0, '0);
		add_imm("slli", f3_sll, alu_sll, 1, f7_base);
		add_imm("srli", f3_sr, alu_srl, 1, f7_base);
		gap_next = 1;
		add_imm("srai", f3_sr, alu_sra, 1, f7_alt);
		gap_next = 0;
		add_upper("lui", op_lui);
		add_upper("auipc", op_auipc);
		add_branch("beq", f3_beq, btu_beq);
		add_branch("bne", f3_bne, btu_bne);
		add_branch("blt", f3_blt, btu_blt);
		add_branch("bge", f3_bge, btu_bge);
		add_branch("bltu", f3_bltu, btu_bltu);
		add_branch("bgeu", f3_bgeu, btu_bgeu);
		add_jumps();
		add_reg("mul", f7_muldiv, f3_mul, fu_mult, mult_mul);
		add_reg("mulh", f7_muldiv, f3_mulh, fu_mult, mult_mulh);
		add_reg("mulhsu", f7_muldiv, f3_mulhsu, fu_mult, mult_mulhsu);
		add_reg("mulhu", f7_muldiv, f3_mulhu, fu_mult, mult_mulhu);
		add_row("lw", {12'($urandom), 5'd3, f3_word, 5'd9, op_load}, k_issue, fu_lsu, '0);
		add_row("sw", {7'h0, 5'd4, 5'd2, f3_word, 5'h10, op_store}, k_issue, fu_lsu, '0);
		add_row("csrrs", {12'h300, 5'd1, f3_csrrs, 5'd2, op_system}, k_csr, fu_alu, '0);
		add_row("all ones", 32'hffff_ffff, k_ill, fu_alu, '0);
		add_row("div", {f7_muldiv, 5'd1, 5'd2, 3'b100, 5'd3, op_reg}, k_ill, fu_alu, '0);
		// flush arrives while the next two instructions are in flight
		add_reg("before flush", f7_base, f3_add, fu_alu, alu_add);
		expect_drop = 1;
		add_imm("flushed in latch", f3_or, alu_or, 0, '0);
		flush_next = 1;
		add_reg("flushed at input", f7_base, f3_xor, fu_alu, alu_xor);
		flush_next = 0;
		expect_drop = 0;
		add_reg("after flush", f7_alt, f3_add, fu_alu, alu_sub);
		add_row("wfi", inst_wfi, k_halt, fu_alu, '0);
		expect_drop = 1;
		add_reg("after wfi add", f7_base, f3_add, fu_alu, alu_add);
		add_row("after wfi csr", {12'h300, 5'd1, f3_csrrw, 5'd2, op_system}, k_csr, fu_alu, '0);
		add_reg("after wfi mul", f7_muldiv, f3_mul, fu_mult, mult_mul);
	endtask

	task automatic drive_row(input int i);
		logic [3:0] pulses;
		logic [55:0] f;
		logic [127:0] exp, mask;
		bit lsu;
		f = row_fields[i];
		lsu = (row_fu[i] == fu_lsu);
		pulses = '0;
		if (row_kind[i] == k_issue) begin
			pulses[3 - int'(row_fu[i])] = 1'b1;
			count_exp++;
		end
		if (row_kind[i] == k_halt) begin
			halted_exp = 1;
		end
		in_valid = 1'b1;
		inst = row_word[i];
		in_pc = row_pc[i];
		flush = row_flush[i];
		exp = {17'b0, halted_exp, count_exp, pulses, row_kind[i] == k_csr,
			row_kind[i] == k_ill, f, row_pc[i]};
		mask = {17'b0, 1'b1, 16'hffff, 6'h3f, 88'b0};
		if (row_kind[i] == k_issue) begin
			mask[87:32] = {{5{!lsu}}, {5{f[3] && !lsu}}, {5{f[2] && !lsu}}, {5{!lsu}},
				{32{f[1] && !lsu}}, 4'hf};
			mask[31:0] = '1;
		end
		u_checker.expect_row(row_name[i], u_checker.cycle + 2, exp, mask);
	endtask

	initial begin
		int gaps;
		void'($urandom(32'h2e02_7339));
		build_table();
		gaps = 0;
		foreach (row_gap[i]) gaps += row_gap[i];
		limit = row_word.size() + gaps + 8 + 20;
		repeat (8) @(posedge clock);
		#1 reset = 1'b0;
		foreach (row_word[i]) begin
			@(posedge clock);
			#1 drive_row(i);
			if (row_gap[i]) begin
				@(posedge clock);
				#1 in_valid = 1'b0;
				flush = 1'b0;
			end
		end
		@(posedge clock);
		#1 in_valid = 1'b0;
		flush = 1'b0;
		while (u_checker.due_q.size() != 0) @(posedge clock);
		// only reset may clear the halt state and the counter
		#1 reset = 1'b1;
		repeat (2) @(posedge clock);
		#1 reset = 1'b0;
		@(negedge clock);
		u_checker.check_idle("final reset");
		$display("%0d passed, %0d failed", u_checker.pass_count, u_checker.fail_count);
		if (u_checker.fail_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	always @(posedge clock) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("run did not finish within %0d cycles", limit);
			$display("Test failed");
			$finish;
		end
	end

endmodule

// File: verif/frontend_checker.sv
`timescale 1ns/1ps

module frontend_checker import isa_pkg::*, decode_pkg::*; (
	input logic                 clock,
	input logic                 reset,
	input logic                 issue_alu,
	input logic                 issue_btu,
	input logic                 issue_mult,
	input logic                 issue_lsu,
	input logic [xlen-1:0]      out_pc,
	input op_func_t             out_func,
	input logic [reg_idx_w-1:0] out_src1,
	input logic [reg_idx_w-1:0] out_src2,
	input logic [reg_idx_w-1:0] out_dest,
	input logic [xlen-1:0]      out_imm,
	input logic                 out_rs1_valid,
	input logic                 out_rs2_valid,
	input logic                 out_imm_valid,
	input logic                 out_pc_valid,
	input logic                 csr_op,
	input logic                 illegal,
	input logic                 halted,
	input logic [count_w-1:0]   dispatch_count
);

	int cycle = 0;
	int pass_count = 0;
	int fail_count = 0;

	// pending expectations, oldest first
	string        name_q[$];
	int           due_q[$];
	logic [127:0] exp_q[$];
	logic [127:0] mask_q[$];

	logic [127:0] seen;
	logic         pulse;

	// same field order the testbench uses to build its expected words
	assign seen = {17'b0, halted, dispatch_count,
		issue_alu, issue_btu, issue_mult, issue_lsu, csr_op, illegal,
		out_func, out_src1, out_src2, out_dest, out_imm,
		out_rs1_valid, out_rs2_valid, out_imm_valid, out_pc_valid, out_pc};
	assign pulse = issue_alu | issue_btu | issue_mult | issue_lsu | csr_op | illegal;

	task automatic expect_row(input string name, input int due, input logic [127:0] exp,
			input logic [127:0] mask);
		name_q.push_back(name);
		due_q.push_back(due);
		exp_q.push_back(exp);
		mask_q.push_back(mask);
	endtask

	task automatic compare(input string name, input logic [127:0] exp, input logic [127:0] mask);
		if ((seen & mask) === (exp & mask)) begin
			pass_count++;
			$display("pass %s", name);
		end else begin
			fail_count++;
			$display("Fail %s expected %h actual %h", name, exp & mask, seen & mask);
		end
	endtask

	// after reset only halted, the counter and the pulses have a defined value
	task automatic check_idle(input string name);
		compare(name, '0, {17'b0, 1'b1, 16'hffff, 6'h3f, 88'b0});
	endtask

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	// registered outputs have settled by the falling edge
	always @(negedge clock) begin
		if (!reset) begin
			if (due_q.size() != 0 && due_q[0] == cycle) begin
				void'(due_q.pop_front());
				if (exp_q[0][93:88] != 6'b0 && !pulse) begin
					fail_count++;
					$display("expected output pulse for %s never arrived", name_q.pop_front());
					void'(exp_q.pop_front());
					void'(mask_q.pop_front());
				end else begin
					compare(name_q.pop_front(), exp_q.pop_front(), mask_q.pop_front());
				end
			end else if (pulse) begin
				fail_count++;
				$display("output pulse at cycle %0d with no instruction expecting it", cycle);
			end
		end
	end

endmodule

// File: design/frontend_top.sv
`timescale 1ns/1ps

module frontend_top import isa_pkg::*, decode_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush,
	input  logic                 in_valid,
	input  logic [xlen-1:0]      inst,
	input  logic [xlen-1:0]      in_pc,
	output logic                 issue_alu,
	output logic                 issue_btu,
	output logic                 issue_mult,
	output logic                 issue_lsu,
	output logic [xlen-1:0]      out_pc,
	output op_func_t             out_func,
	output logic [reg_idx_w-1:0] out_src1,
	output logic [reg_idx_w-1:0] out_src2,
	output logic [reg_idx_w-1:0] out_dest,
	output logic [xlen-1:0]      out_imm,
	output logic                 out_rs1_valid,
	output logic                 out_rs2_valid,
	output logic                 out_imm_valid,
	output logic                 out_pc_valid,
	output logic                 csr_op,
	output logic                 illegal,
	output logic                 halted,
	output logic [count_w-1:0]   dispatch_count
);

	// fetch latch to decoder
	logic            fl_valid;
	logic [xlen-1:0] fl_inst;
	logic [xlen-1:0] fl_pc;

	// decoder to dispatch
	logic                 dec_valid;
	fu_t                  dec_fu;
	op_func_t             dec_func;
	logic [reg_idx_w-1:0] dec_src1;
	logic [reg_idx_w-1:0] dec_src2;
	logic [reg_idx_w-1:0] dec_dest;
	logic [xlen-1:0]      dec_imm;
	logic                 dec_rs1_valid;
	logic                 dec_rs2_valid;
	logic                 dec_imm_valid;
	logic                 dec_pc_valid;
	logic [xlen-1:0]      dec_pc;
	logic                 dec_csr_op;
	logic                 dec_halt;
	logic                 dec_illegal;

	fetch_latch u_fetch_latch (
		.clock    (clock),
		.reset    (reset),
		.flush    (flush),
		.halted   (halted),
		.in_valid (in_valid),
		.inst     (inst),
		.in_pc    (in_pc),
		.fl_valid (fl_valid),
		.fl_inst  (fl_inst),
		.fl_pc    (fl_pc)
	);

	decoder u_decoder (
		.in_valid      (fl_valid),
		.inst          (fl_inst),
		.in_pc         (fl_pc),
		.dec_valid     (dec_valid),
		.dec_fu        (dec_fu),
		.dec_func      (dec_func),
		.dec_src1      (dec_src1),
		.dec_src2      (dec_src2),
		.dec_dest      (dec_dest),
		.dec_imm       (dec_imm),
		.dec_rs1_valid (dec_rs1_valid),
		.dec_rs2_valid (dec_rs2_valid),
		.dec_imm_valid (dec_imm_valid),
		.dec_pc_valid  (dec_pc_valid),
		.dec_pc        (dec_pc),
		.csr_op        (dec_csr_op),
		.halt          (dec_halt),
		.illegal       (dec_illegal)
	);

	dispatch_stage u_dispatch_stage (
		.clock          (clock),
		.reset          (reset),
		.flush          (flush),
		.dec_valid      (dec_valid),
		.dec_fu         (dec_fu),
		.dec_func       (dec_func),
		.dec_src1       (dec_src1),
		.dec_src2       (dec_src2),
		.dec_dest       (dec_dest),
		.dec_imm        (dec_imm),
		.dec_rs1_valid  (dec_rs1_valid),
		.dec_rs2_valid  (dec_rs2_valid),
		.dec_imm_valid  (dec_imm_valid),
		.dec_pc_valid   (dec_pc_valid),
		.dec_pc         (dec_pc),
		.dec_csr_op     (dec_csr_op),
		.dec_halt       (dec_halt),
		.dec_illegal    (dec_illegal),
		.issue_alu      (issue_alu),
		.issue_btu      (issue_btu),
		.issue_mult     (issue_mult),
		.issue_lsu      (issue_lsu),
		.out_pc         (out_pc),
		.out_func       (out_func),
		.out_src1       (out_src1),
		.out_src2       (out_src2),
		.out_dest       (out_dest),
		.out_imm        (out_imm),
		.out_rs1_valid  (out_rs1_valid),
		.out_rs2_valid  (out_rs2_valid),
		.out_imm_valid  (out_imm_valid),
		.out_pc_valid   (out_pc_valid),
		.csr_op         (csr_op),
		.illegal        (illegal),
		.halted         (halted),
		.dispatch_count (dispatch_count)
	);

endmodule

// File: design/dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage import isa_pkg::*, decode_pkg::*; (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 flush,
	input  logic                 dec_valid,
	input  fu_t                  dec_fu,
	input  op_func_t             dec_func,
	input  logic [reg_idx_w-1:0] dec_src1,
	input  logic [reg_idx_w-1:0] dec_src2,
	input  logic [reg_idx_w-1:0] dec_dest,
	input  logic [xlen-1:0]      dec_imm,
	input  logic                 dec_rs1_valid,
	input  logic                 dec_rs2_valid,
	input  logic                 dec_imm_valid,
	input  logic                 dec_pc_valid,
	input  logic [xlen-1:0]      dec_pc,
	input  logic                 dec_csr_op,
	input  logic                 dec_halt,
	input  logic                 dec_illegal,
	output logic                 issue_alu,
	output logic                 issue_btu,
	output logic                 issue_mult,
	output logic                 issue_lsu,
	output logic [xlen-1:0]      out_pc,
	output op_func_t             out_func,
	output logic [reg_idx_w-1:0] out_src1,
	output logic [reg_idx_w-1:0] out_src2,
	output logic [reg_idx_w-1:0] out_dest,
	output logic [xlen-1:0]      out_imm,
	output logic                 out_rs1_valid,
	output logic                 out_rs2_valid,
	output logic                 out_imm_valid,
	output logic                 out_pc_valid,
	output logic                 csr_op,
	output logic                 illegal,
	output logic                 halted,
	output logic [count_w-1:0]   dispatch_count
);

	logic take;
	logic issue_ok;

	// anything still arriving after halt or during flush is dropped
	assign take     = !halted && !flush;
	assign issue_ok = take && dec_valid && !dec_csr_op && !dec_halt;

	always_ff @(posedge clock) begin
		if (reset) begin
			issue_alu      <= 1'b0;
			issue_btu      <= 1'b0;
			issue_mult     <= 1'b0;
			issue_lsu      <= 1'b0;
			csr_op         <= 1'b0;
			illegal        <= 1'b0;
			halted         <= 1'b0;
			dispatch_count <= '0;
		end else begin
			issue_alu  <= issue_ok && dec_fu == fu_alu;
			issue_btu  <= issue_ok && dec_fu == fu_btu;
			issue_mult <= issue_ok && dec_fu == fu_mult;
			issue_lsu  <= issue_ok && dec_fu == fu_lsu;
			csr_op     <= take && dec_csr_op;
			illegal    <= take && dec_illegal;
			// sticky until reset, flush leaves it alone
			if (take && dec_halt) begin
				halted <= 1'b1;
			end
			if (issue_ok) begin
				dispatch_count <= dispatch_count + 1'b1;
			end
		end
	end

	// decoded fields, qualified by the strobes above
	always_ff @(posedge clock) begin
		out_pc        <= dec_pc;
		out_func      <= dec_func;
		out_src1      <= dec_src1;
		out_src2      <= dec_src2;
		out_dest      <= dec_dest;
		out_imm       <= dec_imm;
		out_rs1_valid <= dec_rs1_valid;
		out_rs2_valid <= dec_rs2_valid;
		out_imm_valid <= dec_imm_valid;
		out_pc_valid  <= dec_pc_valid;
	end

	assert property (@(posedge clock) disable iff (reset)
		$onehot0({issue_alu, issue_btu, issue_mult, issue_lsu}))
		else $error("more than one issue strobe active");

	// once halted, no strobe of any kind may leave the front end
	assert property (@(posedge clock) disable iff (reset)
		halted |-> !(issue_alu || issue_btu || issue_mult || issue_lsu || csr_op || illegal))
		else $error("pulse seen while halted");

endmodule

// File: design/decoder.sv
`timescale 1ns/1ps

module decoder import isa_pkg::*, decode_pkg::*; (
	input  logic                 in_valid,
	input  logic [xlen-1:0]      inst,
	input  logic [xlen-1:0]      in_pc,
	output logic                 dec_valid,
	output fu_t                  dec_fu,
	output op_func_t             dec_func,
	output logic [reg_idx_w-1:0] dec_src1,
	output logic [reg_idx_w-1:0] dec_src2,
	output logic [reg_idx_w-1:0] dec_dest,
	output logic [xlen-1:0]      dec_imm,
	output logic                 dec_rs1_valid,
	output logic                 dec_rs2_valid,
	output logic                 dec_imm_valid,
	output logic                 dec_pc_valid,
	output logic [xlen-1:0]      dec_pc,
	output logic                 csr_op,
	output logic                 halt,
	output logic                 illegal
);

	logic [6:0]           opcode;
	logic [2:0]           funct3;
	logic [6:0]           funct7;
	logic [reg_idx_w-1:0] rs1;
	logic [reg_idx_w-1:0] rs2;
	logic [reg_idx_w-1:0] rd;

	// alt selects sub or sra for the two funct3 codes that have them
	function automatic op_func_t alu_op(input logic [2:0] f3, input logic alt);
		alu_op = alu_add;
		case (f3)
			f3_add:  alu_op = alt ? alu_sub : alu_add;
			f3_sll:  alu_op = alu_sll;
			f3_slt:  alu_op = alu_slt;
			f3_sltu: alu_op = alu_sltu;
			f3_xor:  alu_op = alu_xor;
			f3_sr:   alu_op = alt ? alu_sra : alu_srl;
			f3_or:   alu_op = alu_or;
			f3_and:  alu_op = alu_and;
		endcase
	endfunction

	assign opcode = inst[6:0];
	assign funct3 = inst[f3_lsb +: 3];
	assign funct7 = inst[f7_lsb +: 7];
	assign rs1    = inst[rs1_lsb +: reg_idx_w];
	assign rs2    = inst[rs2_lsb +: reg_idx_w];
	assign rd     = inst[rd_lsb +: reg_idx_w];

	// csr and wfi stay valid here, dispatch decides what to do with them
	assign dec_valid = in_valid & ~illegal;

	always_comb begin
		// noop defaults
		dec_fu        = fu_alu;
		dec_func      = alu_add;
		dec_src1      = '0;
		dec_src2      = '0;
		dec_dest      = '0;
		dec_imm       = '0;
		dec_rs1_valid = 1'b0;
		dec_rs2_valid = 1'b0;
		dec_imm_valid = 1'b0;
		dec_pc_valid  = 1'b0;
		dec_pc        = '0;
		csr_op        = 1'b0;
		halt          = 1'b0;
		illegal       = 1'b0;

		if (in_valid) begin
			dec_pc = in_pc;
			case (opcode)
				op_lui, op_auipc: begin
					dec_dest      = rd;
					dec_imm       = imm_u(inst);
					dec_imm_valid = 1'b1;
					dec_pc_valid  = (opcode == op_auipc);
				end
				op_jal: begin
					dec_fu        = fu_btu;
					dec_func      = btu_jal;
					dec_dest      = rd;
					dec_imm       = imm_j(inst);
					dec_imm_valid = 1'b1;
					dec_pc_valid  = 1'b1;
				end
				op_jalr: begin
					dec_fu        = fu_btu;
					dec_func      = btu_jalr;
					dec_src1      = rs1;
					dec_dest      = rd;
					dec_imm       = imm_i(inst);
					dec_rs1_valid = 1'b1;
					dec_imm_valid = 1'b1;
					dec_pc_valid  = 1'b1;
					illegal       = (funct3 != f3_jalr);
				end
				op_branch: begin
					dec_fu        = fu_btu;
					dec_src1      = rs1;
					dec_src2      = rs2;
					dec_imm       = imm_b(inst);
					dec_rs1_valid = 1'b1;
					dec_rs2_valid = 1'b1;
					dec_imm_valid = 1'b1;
					dec_pc_valid  = 1'b1;
					case (funct3)
						f3_beq:  dec_func = btu_beq;
						f3_bne:  dec_func = btu_bne;
						f3_blt:  dec_func = btu_blt;
						f3_bge:  dec_func = btu_bge;
						f3_bltu: dec_func = btu_bltu;
						f3_bgeu: dec_func = btu_bgeu;
						default: illegal = 1'b1;
					endcase
				end
				// memory ops only carry the unit tag for now
				op_load: begin
					dec_fu  = fu_lsu;
					illegal = !(funct3 inside {f3_byte, f3_half, f3_word, f3_byte_u, f3_half_u});
				end
				op_store: begin
					dec_fu  = fu_lsu;
					illegal = !(funct3 inside {f3_byte, f3_half, f3_word});
				end
				op_imm: begin
					dec_src1      = rs1;
					dec_dest      = rd;
					dec_imm       = imm_i(inst);
					dec_rs1_valid = 1'b1;
					dec_imm_valid = 1'b1;
					// only shifts look at the upper bits as funct7
					dec_func = alu_op(funct3, funct3 == f3_sr && funct7 == f7_alt);
					if (funct3 == f3_sll) begin
						illegal = (funct7 != f7_base);
					end else if (funct3 == f3_sr) begin
						illegal = !(funct7 inside {f7_base, f7_alt});
					end
				end
				op_reg: begin
					dec_src1      = rs1;
					dec_src2      = rs2;
					dec_dest      = rd;
					dec_rs1_valid = 1'b1;
					dec_rs2_valid = 1'b1;
					if (funct7 == f7_muldiv) begin
						dec_fu = fu_mult;
						case (funct3)
							f3_mul:    dec_func = mult_mul;
							f3_mulh:   dec_func = mult_mulh;
							f3_mulhsu: dec_func = mult_mulhsu;
							f3_mulhu:  dec_func = mult_mulhu;
							// no divider in this core
							default:   illegal = 1'b1;
						endcase
					end else if (funct7 == f7_base) begin
						dec_func = alu_op(funct3, 1'b0);
					end else if (funct7 == f7_alt && funct3 inside {f3_add, f3_sr}) begin
						dec_func = alu_op(funct3, 1'b1);
					end else begin
						illegal = 1'b1;
					end
				end
				op_system: begin
					if (inst == inst_wfi) begin
						halt = 1'b1;
					end else if (funct3 inside {f3_csrrw, f3_csrrs, f3_csrrc}) begin
						csr_op = 1'b1;
					end else begin
						illegal = 1'b1;
					end
				end
				default: illegal = 1'b1;
			endcase
		end
	end

endmodule

// File: design/fetch_latch.sv
`timescale 1ns/1ps

module fetch_latch import isa_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	input  logic            flush,
	input  logic            halted,
	input  logic            in_valid,
	input  logic [xlen-1:0] inst,
	input  logic [xlen-1:0] in_pc,
	output logic            fl_valid,
	output logic [xlen-1:0] fl_inst,
	output logic [xlen-1:0] fl_pc
);

	// valid bit, dropped on flush and refused once the core has halted
	always_ff @(posedge clock) begin
		if (reset || flush || halted) begin
			fl_valid <= 1'b0;
		end else begin
			fl_valid <= in_valid;
		end
	end

	// word and pc are simply sampled every cycle
	always_ff @(posedge clock) begin
		fl_inst <= inst;
		fl_pc   <= in_pc;
	end

	// halted comes from dispatch, so this ties the two stages together
	// nothing may be held here one cycle after halt was seen
	assert property (@(posedge clock) disable iff (reset)
		$past(halted) |-> !fl_valid)
		else $error("fetch latch holds an instruction after halt");

endmodule

// File: design/decode_pkg.sv
package decode_pkg;

	// dispatch counter width
	localparam int count_w = 16;

	// target functional unit
	typedef enum logic [1:0] {
		fu_alu,
		fu_btu,
		fu_mult,
		fu_lsu
	} fu_t;

	// operation within the selected unit
	typedef enum logic [4:0] {
		alu_add,
		alu_sub,
		alu_slt,
		alu_sltu,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		// branch unit, jumps included
		btu_jal,
		btu_jalr,
		btu_beq,
		btu_bne,
		btu_blt,
		btu_bge,
		btu_bltu,
		btu_bgeu,
		// multiplier
		mult_mul,
		mult_mulh,
		mult_mulhsu,
		mult_mulhu
	} op_func_t;

endpackage

// File: design/isa_pkg.sv
package isa_pkg;

	// datapath and register file geometry
	localparam int xlen      = 32;
	localparam int reg_idx_w = 5;

	// field positions inside a 32-bit instruction word
	localparam int rd_lsb  = 7;
	localparam int f3_lsb  = 12;
	localparam int rs1_lsb = 15;
	localparam int rs2_lsb = 20;
	localparam int f7_lsb  = 25;

	// major opcodes
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_system = 7'b1110011;

	// funct7 variants
	localparam logic [6:0] f7_base   = 7'b0000000;
	localparam logic [6:0] f7_alt    = 7'b0100000;
	localparam logic [6:0] f7_muldiv = 7'b0000001;

	// branch compare codes
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;
	localparam logic [2:0] f3_jalr = 3'b000;

	// alu codes, shared by register and immediate forms
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_sr   = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// multiply codes under f7_muldiv
	localparam logic [2:0] f3_mul    = 3'b000;
	localparam logic [2:0] f3_mulh   = 3'b001;
	localparam logic [2:0] f3_mulhsu = 3'b010;
	localparam logic [2:0] f3_mulhu  = 3'b011;

	// memory access sizes, loads use all five and stores the first three
	localparam logic [2:0] f3_byte   = 3'b000;
	localparam logic [2:0] f3_half   = 3'b001;
	localparam logic [2:0] f3_word   = 3'b010;
	localparam logic [2:0] f3_byte_u = 3'b100;
	localparam logic [2:0] f3_half_u = 3'b101;

	// csr access codes
	localparam logic [2:0] f3_csrrw = 3'b001;
	localparam logic [2:0] f3_csrrs = 3'b010;
	localparam logic [2:0] f3_csrrc = 3'b011;

	localparam logic [xlen-1:0] inst_wfi = 32'h1050_0073;

	// sign-extended immediates per format
	function automatic logic [xlen-1:0] imm_i(input logic [xlen-1:0] w);
		imm_i = {{20{w[31]}}, w[31:20]};
	endfunction

	function automatic logic [xlen-1:0] imm_b(input logic [xlen-1:0] w);
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
	endfunction

	function automatic logic [xlen-1:0] imm_u(input logic [xlen-1:0] w);
		imm_u = {w[31:12], 12'b0};
	endfunction

	function automatic logic [xlen-1:0] imm_j(input logic [xlen-1:0] w);
		imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
	endfunction

endpackage
